/* source/ni_config.svh */
////////////////////////////////////////////////////////////
// sizing macros for the DMA send NI and its register bits
////////////////////////////////////////////////////////////
`ifndef NI_CONFIG_SVH
`define NI_CONFIG_SVH

`define NI_NUM_CH   4       // send channels, one virtual channel each
`define NI_DATA_W   32      // memory word and flit payload
`define NI_MADDR_W  16      // memory word address
`define NI_SIZE_W   8       // packet size in words
`define NI_EADDR_W  8       // endpoint address
`define NI_CREDITS  4       // downstream buffer depth per channel
`define NI_CH_W     2       // channel index

// bit positions in CTRL writes and STATUS reads
// bit 0 is start on a CTRL write and busy on a STATUS read
`define NI_BIT_START    0
`define NI_BIT_DONE     1
`define NI_BIT_INVALID  2
`define NI_BIT_ZERO     3
`define NI_BIT_IEN      4

`endif

/* source/ni_pkg.sv */
////////////////////////////////////////////////////////////
// enums and packed structs shared across the send NI
////////////////////////////////////////////////////////////
`include "ni_config.svh"

package ni_pkg;

    // flit type field, header and tail flags as two bits
    typedef enum logic [1:0] {
        BODY = 2'b00,
        TAIL = 2'b01,
        HDR  = 2'b10
    } flit_kind_e;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_GRANT,
        SEND_HDR,   // granted, header held back by credit
        READ,
        FINISH
    } send_state_e;

    // register offsets inside one channel's register set
    typedef enum logic [2:0] {
        CTRL    = 3'd0,
        DEST    = 3'd1,
        POINTER = 3'd2,
        SIZE    = 3'd3,
        STATUS  = 3'd4
    } csr_reg_e;

    typedef struct packed {
        logic                    stb;
        logic                    we;
        logic [`NI_CH_W-1:0]     ch;
        csr_reg_e                reg_sel;
        logic [`NI_DATA_W-1:0]   wdata;
    } csr_req_t;

    typedef struct packed {
        logic                    start;     // one-cycle launch strobe
        logic [`NI_EADDR_W-1:0]  dest;
        logic [`NI_MADDR_W-1:0]  pointer;
        logic [`NI_SIZE_W-1:0]   size;
    } ch_cmd_t;

    typedef struct packed {
        logic                    stb;
        logic [`NI_MADDR_W-1:0]  addr;
    } mem_req_t;

    typedef struct packed {
        logic                    ack;
        logic [`NI_DATA_W-1:0]   data;
    } mem_rsp_t;

    typedef struct packed {
        logic                    valid;
        flit_kind_e              kind;
        logic [`NI_CH_W-1:0]     ch;
        logic [`NI_DATA_W-1:0]   payload;
    } flit_t;

endpackage

/* source/ni_csr.sv */
////////////////////////////////////////////////////////////
// register bank: channel commands, flags and interrupt
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "ni_config.svh"

module ni_csr
    import ni_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset,
    input  csr_req_t                     csr_req_i,
    output logic [`NI_DATA_W-1:0]        csr_rdata_o,
    output logic                         csr_ack_o,
    output ch_cmd_t [`NI_NUM_CH-1:0]     ch_cmd_o,
    input  logic [`NI_NUM_CH-1:0]        busy_i,
    input  logic [`NI_NUM_CH-1:0]        done_i,
    output logic                         irq_o
);

    logic [`NI_EADDR_W-1:0]  dest_q    [`NI_NUM_CH];
    logic [`NI_MADDR_W-1:0]  pointer_q [`NI_NUM_CH];
    logic [`NI_SIZE_W-1:0]   size_q    [`NI_NUM_CH];

    logic [`NI_NUM_CH-1:0]   start_q;
    logic [`NI_NUM_CH-1:0]   done_q;
    logic [`NI_NUM_CH-1:0]   invalid_q;   // start while busy
    logic [`NI_NUM_CH-1:0]   zero_q;      // start with size 0
    logic [`NI_NUM_CH-1:0]   ien_q;

    logic                    wr_stb;
    logic [`NI_NUM_CH-1:0]   ctrl_wr;
    logic [`NI_NUM_CH-1:0]   start_req;
    logic [`NI_NUM_CH-1:0]   ch_busy;
    logic [`NI_NUM_CH-1:0]   size_zero;
    logic [`NI_DATA_W-1:0]   rdata_next;

    assign wr_stb = csr_req_i.stb & csr_req_i.we;

    always_comb begin
        for (int i = 0; i < `NI_NUM_CH; i++) begin
            ctrl_wr[i]   = wr_stb && (csr_req_i.reg_sel == CTRL)
                           && (csr_req_i.ch == `NI_CH_W'(i));
            start_req[i] = ctrl_wr[i] && csr_req_i.wdata[`NI_BIT_START];
            // a launched strobe counts as busy until the channel answers
            ch_busy[i]   = busy_i[i] | start_q[i];
            size_zero[i] = (size_q[i] == '0);
        end
    end

    // command registers
    always_ff @(posedge clk) begin
        if (wr_stb) begin
            case (csr_req_i.reg_sel)
                DEST:    dest_q[csr_req_i.ch]    <= csr_req_i.wdata[`NI_EADDR_W-1:0];
                POINTER: pointer_q[csr_req_i.ch] <= csr_req_i.wdata[`NI_MADDR_W-1:0];
                SIZE:    size_q[csr_req_i.ch]    <= csr_req_i.wdata[`NI_SIZE_W-1:0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            start_q   <= '0;
            done_q    <= '0;
            invalid_q <= '0;
            zero_q    <= '0;
            ien_q     <= '0;
            csr_ack_o <= 1'b0;
        end else begin
            csr_ack_o <= csr_req_i.stb;
            for (int i = 0; i < `NI_NUM_CH; i++) begin
                start_q[i] <= start_req[i] && !ch_busy[i] && !size_zero[i];
                // a new done wins over a clear in the same cycle
                if (done_i[i])
                    done_q[i] <= 1'b1;
                else if (ctrl_wr[i] && csr_req_i.wdata[`NI_BIT_DONE])
                    done_q[i] <= 1'b0;
                if (start_req[i] && ch_busy[i])
                    invalid_q[i] <= 1'b1;
                else if (ctrl_wr[i] && csr_req_i.wdata[`NI_BIT_INVALID])
                    invalid_q[i] <= 1'b0;
                if (start_req[i] && !ch_busy[i] && size_zero[i])
                    zero_q[i] <= 1'b1;
                else if (ctrl_wr[i] && csr_req_i.wdata[`NI_BIT_ZERO])
                    zero_q[i] <= 1'b0;
                if (ctrl_wr[i])
                    ien_q[i] <= csr_req_i.wdata[`NI_BIT_IEN];
            end
        end
    end

    always_comb begin
        rdata_next = '0;
        case (csr_req_i.reg_sel)
            DEST:    rdata_next[`NI_EADDR_W-1:0] = dest_q[csr_req_i.ch];
            POINTER: rdata_next[`NI_MADDR_W-1:0] = pointer_q[csr_req_i.ch];
            SIZE:    rdata_next[`NI_SIZE_W-1:0]  = size_q[csr_req_i.ch];
            STATUS: begin
                rdata_next[`NI_BIT_START]   = ch_busy[csr_req_i.ch];
                rdata_next[`NI_BIT_DONE]    = done_q[csr_req_i.ch];
                rdata_next[`NI_BIT_INVALID] = invalid_q[csr_req_i.ch];
                rdata_next[`NI_BIT_ZERO]    = zero_q[csr_req_i.ch];
                rdata_next[`NI_BIT_IEN]     = ien_q[csr_req_i.ch];
            end
            default: ;  // CTRL reads as zero
        endcase
    end

    always_ff @(posedge clk) begin
        if (csr_req_i.stb)
            csr_rdata_o <= rdata_next;   // valid with the ack
    end

    always_comb begin
        for (int i = 0; i < `NI_NUM_CH; i++) begin
            ch_cmd_o[i].start   = start_q[i];
            ch_cmd_o[i].dest    = dest_q[i];
            ch_cmd_o[i].pointer = pointer_q[i];
            ch_cmd_o[i].size    = size_q[i];
        end
    end

    assign irq_o = |(done_q & ien_q);

    // strobes are single cycle with a gap, so acks never touch
    a_ack_gap: assert property (@(posedge clk) disable iff (reset)
        csr_ack_o |=> !csr_ack_o)
        else $error("ERROR: csr_ack_o high in two cycles in a row");

endmodule

/* source/ni_send_channel.sv */
////////////////////////////////////////////////////////////
// one send channel: packet FSM, read address, credit count
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "ni_config.svh"

module ni_send_channel
    import ni_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  ch_cmd_t                  cmd_i,
    input  logic [`NI_EADDR_W-1:0]   src_addr_i,
    input  logic                     grant_i,
    input  mem_rsp_t                 mem_rsp_i,
    input  logic                     credit_i,
    output logic                     active_o,
    output logic                     busy_o,
    output logic                     done_o,
    output mem_req_t                 mem_req_o,
    output flit_t                    flit_o
);

    localparam int CRED_W = $clog2(`NI_CREDITS + 1);
    localparam int HDR_PAD = `NI_DATA_W - `NI_SIZE_W - 2 * `NI_EADDR_W;

    send_state_e              state_q;
    send_state_e              state_d;

    logic [`NI_EADDR_W-1:0]   dest_q;
    logic [`NI_MADDR_W-1:0]   addr_q;
    logic [`NI_SIZE_W-1:0]    size_q;     // word count for the header
    logic [`NI_SIZE_W-1:0]    remain_q;   // words still to read
    logic                     pending_q;  // read strobe out, waiting for ack
    logic [CRED_W-1:0]        credit_q;

    logic                     has_credit;
    logic                     hdr_send;
    logic                     rd_issue;
    logic                     rd_done;
    logic                     last_word;

    assign has_credit = (credit_q != '0);
    assign last_word  = (remain_q == `NI_SIZE_W'(1));

    // header goes in the first granted cycle that has a credit
    assign hdr_send = grant_i && has_credit
                      && (state_q == WAIT_GRANT || state_q == SEND_HDR);
    assign rd_issue = (state_q == READ) && !pending_q && has_credit;
    assign rd_done  = (state_q == READ) && pending_q && mem_rsp_i.ack;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (cmd_i.start)
                    state_d = WAIT_GRANT;
            end
            WAIT_GRANT: begin
                if (hdr_send)
                    state_d = READ;
                else if (grant_i)
                    state_d = SEND_HDR;   // granted but out of credit
            end
            SEND_HDR: begin
                if (hdr_send)
                    state_d = READ;
            end
            READ: begin
                if (rd_done && last_word)
                    state_d = FINISH;
            end
            FINISH:  state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q   <= IDLE;
            pending_q <= 1'b0;
            credit_q  <= CRED_W'(`NI_CREDITS);
        end else begin
            state_q <= state_d;
            if (rd_issue)
                pending_q <= 1'b1;
            else if (rd_done)
                pending_q <= 1'b0;
            // a flit and a returned credit in one cycle cancel out
            case ({flit_o.valid, credit_i})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   credit_q <= credit_q + 1'b1;
                default: ;
            endcase
        end
    end

    // packet fields, latched at launch
    always_ff @(posedge clk) begin
        if (state_q == IDLE && cmd_i.start) begin
            dest_q   <= cmd_i.dest;
            addr_q   <= cmd_i.pointer;
            size_q   <= cmd_i.size;
            remain_q <= cmd_i.size;
        end else if (rd_done) begin
            addr_q   <= addr_q + 1'b1;
            remain_q <= remain_q - 1'b1;
        end
    end

    assign active_o = (state_q == WAIT_GRANT) || (state_q == SEND_HDR) || (state_q == READ);
    assign busy_o   = (state_q != IDLE);
    assign done_o   = (state_q == FINISH);

    assign mem_req_o.stb  = rd_issue;
    assign mem_req_o.addr = addr_q;

    always_comb begin
        flit_o = '0;    // channel index is stamped by the arbiter
        if (hdr_send) begin
            flit_o.valid   = 1'b1;
            flit_o.kind    = HDR;
            flit_o.payload = {{HDR_PAD{1'b0}}, size_q, src_addr_i, dest_q};
        end else if (rd_done) begin
            flit_o.valid   = 1'b1;
            flit_o.kind    = last_word ? TAIL : BODY;
            flit_o.payload = mem_rsp_i.data;
        end
    end

    a_flit_credit: assert property (@(posedge clk) disable iff (reset)
        flit_o.valid |-> has_credit)
        else $error("ERROR: flit_o.valid with credit_q=%0h", credit_q);

    // more credits back than were spent
    a_credit_max: assert property (@(posedge clk) disable iff (reset)
        credit_q <= CRED_W'(`NI_CREDITS))
        else $error("ERROR: credit_q=%0h above limit", credit_q);

endmodule

/* source/ni_send_arbiter.sv */
////////////////////////////////////////////////////////////
// round-robin packet arbiter, memory port and flit mux
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "ni_config.svh"

module ni_send_arbiter
    import ni_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic [`NI_NUM_CH-1:0]         active_i,
    input  logic [`NI_NUM_CH-1:0]         done_i,
    input  mem_req_t [`NI_NUM_CH-1:0]     ch_mem_req_i,
    input  flit_t [`NI_NUM_CH-1:0]        ch_flit_i,
    input  mem_rsp_t                      mem_rsp_i,
    output logic [`NI_NUM_CH-1:0]         grant_o,
    output mem_req_t                      mem_req_o,
    output mem_rsp_t [`NI_NUM_CH-1:0]     ch_mem_rsp_o,
    output flit_t                         flit_o
);

    logic [`NI_NUM_CH-1:0]   grant_q;
    logic [`NI_CH_W-1:0]     gnt_idx_q;    // current owner, or the last one served
    logic                    owned;
    logic                    arb_free;
    logic                    pick_found;
    logic [`NI_CH_W-1:0]     pick_idx;

    assign owned    = |grant_q;
    // the owner's done cycle already counts as free
    assign arb_free = !owned || (|(grant_q & done_i));

    // search starts right after the last channel served
    always_comb begin
        int cand;
        pick_found = 1'b0;
        pick_idx   = gnt_idx_q;
        for (int k = 1; k <= `NI_NUM_CH; k++) begin
            cand = (int'(gnt_idx_q) + k) % `NI_NUM_CH;
            if (!pick_found && active_i[cand]) begin
                pick_found = 1'b1;
                pick_idx   = cand[`NI_CH_W-1:0];
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            grant_q   <= '0;
            gnt_idx_q <= `NI_CH_W'(`NI_NUM_CH - 1);   // channel 0 goes first
        end else if (arb_free) begin
            if (pick_found) begin
                grant_q   <= `NI_NUM_CH'(1) << pick_idx;
                gnt_idx_q <= pick_idx;
            end else begin
                grant_q <= '0;
            end
        end
    end

    assign grant_o = grant_q;

    always_comb begin
        mem_req_o = '0;
        flit_o    = '0;
        if (owned) begin
            mem_req_o    = ch_mem_req_i[gnt_idx_q];
            flit_o       = ch_flit_i[gnt_idx_q];
            flit_o.ch    = gnt_idx_q;
        end
    end

    // response goes to the owner only
    always_comb begin
        for (int i = 0; i < `NI_NUM_CH; i++) begin
            ch_mem_rsp_o[i] = grant_q[i] ? mem_rsp_i : '0;
        end
    end

    a_grant_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(grant_q))
        else $error("ERROR: grant_q=%0h not one-hot", grant_q);

endmodule

/* source/ni_top.sv */
////////////////////////////////////////////////////////////
// send NI top: register bank, channels, arbiter
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "ni_config.svh"

module ni_top
    import ni_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic [`NI_EADDR_W-1:0]    src_addr_i,
    input  csr_req_t                  csr_req_i,
    output logic [`NI_DATA_W-1:0]     csr_rdata_o,
    output logic                      csr_ack_o,
    output mem_req_t                  mem_req_o,
    input  mem_rsp_t                  mem_rsp_i,
    input  logic [`NI_NUM_CH-1:0]     credit_i,
    output flit_t                     flit_o,
    output logic                      irq_o
);

    ch_cmd_t  [`NI_NUM_CH-1:0]  ch_cmd;
    logic     [`NI_NUM_CH-1:0]  ch_busy;
    logic     [`NI_NUM_CH-1:0]  ch_done;
    logic     [`NI_NUM_CH-1:0]  ch_active;
    logic     [`NI_NUM_CH-1:0]  ch_grant;
    mem_req_t [`NI_NUM_CH-1:0]  ch_mem_req;
    mem_rsp_t [`NI_NUM_CH-1:0]  ch_mem_rsp;
    flit_t    [`NI_NUM_CH-1:0]  ch_flit;

    ni_csr u_csr (
        .clk         (clk),
        .reset       (reset),
        .csr_req_i   (csr_req_i),
        .csr_rdata_o (csr_rdata_o),
        .csr_ack_o   (csr_ack_o),
        .ch_cmd_o    (ch_cmd),
        .busy_i      (ch_busy),
        .done_i      (ch_done),
        .irq_o       (irq_o)
    );

    for (genvar i = 0; i < `NI_NUM_CH; i++) begin : g_ch
        ni_send_channel u_chan (
            .clk        (clk),
            .reset      (reset),
            .cmd_i      (ch_cmd[i]),
            .src_addr_i (src_addr_i),
            .grant_i    (ch_grant[i]),
            .mem_rsp_i  (ch_mem_rsp[i]),
            .credit_i   (credit_i[i]),
            .active_o   (ch_active[i]),
            .busy_o     (ch_busy[i]),
            .done_o     (ch_done[i]),
            .mem_req_o  (ch_mem_req[i]),
            .flit_o     (ch_flit[i])
        );
    end

    ni_send_arbiter u_arb (
        .clk          (clk),
        .reset        (reset),
        .active_i     (ch_active),
        .done_i       (ch_done),
        .ch_mem_req_i (ch_mem_req),
        .ch_flit_i    (ch_flit),
        .mem_rsp_i    (mem_rsp_i),
        .grant_o      (ch_grant),
        .mem_req_o    (mem_req_o),
        .ch_mem_rsp_o (ch_mem_rsp),
        .flit_o       (flit_o)
    );

endmodule

/* verif/ni_tb.sv */
////////////////////////////////////////////////////////////
// send NI testbench with memory model, credit sink and checks
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "ni_config.svh"

module ni_tb
    import ni_pkg::*;
();

    localparam int PERIOD = 40;
    localparam logic [`NI_DATA_W-1:0]  MEM_KEY  = 32'h5A3C_0000;
    localparam logic [`NI_EADDR_W-1:0] SRC_ADDR = 8'hA5;
    // words sent by the single, stall, four channel, busy start and irq tests
    localparam int TOTAL_WORDS = 3 + 10 + 22 + 5 + 8;
    localparam int WATCHDOG_NS = (TOTAL_WORDS * 16 + 2000) * PERIOD;

    logic                    clk = 1'b0;
    logic                    reset = 1'b1;
    csr_req_t                csr_req = '0;
    logic [`NI_DATA_W-1:0]   csr_rdata;
    logic                    csr_ack;
    mem_req_t                mem_req;
    mem_rsp_t                mem_rsp = '0;
    logic [`NI_NUM_CH-1:0]   credit = '0;
    flit_t                   flit;
    logic                    irq;

    integer seed = 41;
    int value_errs = 0;
    int proto_errs = 0;

    // expected packet fields as written to the registers
    logic [`NI_EADDR_W-1:0]  exp_dest [`NI_NUM_CH];
    logic [`NI_MADDR_W-1:0]  exp_ptr  [`NI_NUM_CH];
    logic [`NI_SIZE_W-1:0]   exp_size [`NI_NUM_CH];
    int start_cnt  [`NI_NUM_CH] = '{default: 0};
    int hdr_cnt    [`NI_NUM_CH] = '{default: 0};
    int pkts_done  [`NI_NUM_CH] = '{default: 0};
    int flits_seen [`NI_NUM_CH] = '{default: 0};
    int owed       [`NI_NUM_CH] = '{default: 0};   // credits held by the sink
    logic [`NI_NUM_CH-1:0] passed_by [`NI_NUM_CH] = '{default: '0};
    logic [`NI_NUM_CH-1:0] withhold = '0;
    logic                  irq_must_low = 1'b0;

    logic                    in_pkt = 1'b0;
    logic [`NI_CH_W-1:0]     cur_ch = '0;
    int                      word_idx = 0;
    logic                    mem_busy = 1'b0;
    int                      mem_wait = 0;
    logic [`NI_MADDR_W-1:0]  mem_addr = '0;

    always #(PERIOD / 2) clk = ~clk;

    ni_top DUT (
        .clk         (clk),
        .reset       (reset),
        .src_addr_i  (SRC_ADDR),
        .csr_req_i   (csr_req),
        .csr_rdata_o (csr_rdata),
        .csr_ack_o   (csr_ack),
        .mem_req_o   (mem_req),
        .mem_rsp_i   (mem_rsp),
        .credit_i    (credit),
        .flit_o      (flit),
        .irq_o       (irq)
    );

    function automatic logic [`NI_DATA_W-1:0] mem_word(input logic [`NI_MADDR_W-1:0] addr);
        return `NI_DATA_W'(addr) ^ MEM_KEY;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got == want) else begin
            value_errs++;
            $display("ERROR: %s expected %h got %h", name, want, got);
        end
    endtask

    // memory with one read in flight and an ack 1 to 3 cycles after the strobe
    always @(posedge clk) begin
        int d;
        mem_rsp <= '0;
        if (mem_busy) begin
            if (mem_wait == 0) begin
                mem_rsp  <= '{ack: 1'b1, data: mem_word(mem_addr)};
                mem_busy <= 1'b0;
            end else
                mem_wait <= mem_wait - 1;
        end
        if (mem_req.stb) begin
            assert (!mem_busy) else begin
                proto_errs++;
                $display("memory read issued while another read was outstanding");
            end
            d = int'({$random(seed)} % 32'd3);
            mem_addr <= mem_req.addr;
            if (d == 0)
                mem_rsp <= '{ack: 1'b1, data: mem_word(mem_req.addr)};
            else begin
                mem_busy <= 1'b1;
                mem_wait <= d - 1;
            end
        end
    end

    // credit sink returns each owed credit after a random delay
    always @(posedge clk) begin
        logic [`NI_NUM_CH-1:0] give;
        for (int c = 0; c < `NI_NUM_CH; c++) begin
            give[c] = !withhold[c] && (owed[c] > 0) && (($random(seed) & 1) != 0);
            credit[c] <= give[c];
            owed[c] <= owed[c] + ((flit.valid && int'(flit.ch) == c) ? 1 : 0)
                       - (give[c] ? 1 : 0);
        end
    end

    // flit scoreboard
    always @(posedge clk) begin
        flit_kind_e want_kind;
        if (irq_must_low)
            check_value("irq_o", 32'(irq), 32'd0);
        if (!reset && flit.valid) begin
            flits_seen[flit.ch]++;
            if (!in_pkt) begin
                check_value("flit.kind", 32'(flit.kind), 32'(HDR));
                check_value("flit.payload", flit.payload,
                            {8'h00, exp_size[flit.ch], SRC_ADDR, exp_dest[flit.ch]});
                assert (hdr_cnt[flit.ch] < start_cnt[flit.ch]) else begin
                    proto_errs++;
                    $display("packet header on channel %0d without a valid start", flit.ch);
                end
                for (int w = 0; w < `NI_NUM_CH; w++) begin
                    if (w != int'(flit.ch) && hdr_cnt[w] < start_cnt[w]) begin
                        assert (!passed_by[w][flit.ch]) else begin
                            proto_errs++;
                            $display("channel %0d served twice while channel %0d waited",
                                     flit.ch, w);
                        end
                        passed_by[w][flit.ch] = 1'b1;
                    end
                end
                passed_by[flit.ch] = '0;
                hdr_cnt[flit.ch]++;
                in_pkt   = 1'b1;
                cur_ch   = flit.ch;
                word_idx = 0;
            end else begin
                want_kind = (word_idx == int'(exp_size[cur_ch]) - 1) ? TAIL : BODY;
                check_value("flit.ch", 32'(flit.ch), 32'(cur_ch));  // no interleaving
                check_value("flit.kind", 32'(flit.kind), 32'(want_kind));
                check_value("flit.payload", flit.payload,
                            mem_word(exp_ptr[cur_ch] + `NI_MADDR_W'(word_idx)));
                word_idx++;
                if (word_idx == int'(exp_size[cur_ch])) begin
                    in_pkt = 1'b0;
                    pkts_done[cur_ch]++;
                end
            end
        end
    end

    a_ack_follows: assert property (@(posedge clk) disable iff (reset)
        csr_req.stb |=> csr_ack)
        else begin
            proto_errs++;
            $display("ERROR: csr_ack_o expected 1 got 0");
        end

    a_ack_spurious: assert property (@(posedge clk) disable iff (reset)
        !csr_req.stb |=> !csr_ack)
        else begin
            proto_errs++;
            $display("ERROR: csr_ack_o expected 0 got 1");
        end

    task automatic csr_access(input logic we, input int ch, input csr_reg_e sel,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int n;
        n = 0;
        @(posedge clk);
        csr_req <= '{stb: 1'b1, we: we, ch: `NI_CH_W'(ch), reg_sel: sel, wdata: wdata};
        @(posedge clk);
        csr_req.stb <= 1'b0;
        do begin
            @(posedge clk);
            n++;
        end while (!csr_ack && n < 8);
        if (!csr_ack) begin
            proto_errs++;
            $display("register access on channel %0d got no ack", ch);
        end
        rdata = csr_rdata;
    endtask

    task automatic csr_write(input int ch, input csr_reg_e sel, input logic [31:0] wdata);
        logic [31:0] unused;
        csr_access(1'b1, ch, sel, wdata, unused);
    endtask

    task automatic setup_channel(input int ch, input logic [7:0] dest,
                                 input logic [15:0] ptr, input logic [7:0] size);
        exp_dest[ch] = dest;
        exp_ptr[ch]  = ptr;
        exp_size[ch] = size;
        csr_write(ch, DEST, 32'(dest));
        csr_write(ch, POINTER, 32'(ptr));
        csr_write(ch, SIZE, 32'(size));
    endtask

    task automatic launch(input int ch, input logic [31:0] extra);
        start_cnt[ch]++;
        csr_write(ch, CTRL, (32'd1 << `NI_BIT_START) | extra);
    endtask

    task automatic wait_packet(input int ch, input int target);
        int n;
        n = 0;
        while (pkts_done[ch] < target && n < 2000) begin
            @(posedge clk);
            n++;
        end
        if (pkts_done[ch] < target) begin
            proto_errs++;
            $display("channel %0d did not finish packet %0d in time", ch, target);
        end
    endtask

    initial begin
        logic [31:0] rd;
        int base;
        int n;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        // register readback
        for (int ch = 0; ch < `NI_NUM_CH; ch++) begin
            setup_channel(ch, 8'h10 + 8'(ch), 16'h0100 * 16'(ch + 1) + 16'h0020, 8'(3 + ch));
            csr_access(1'b0, ch, DEST, '0, rd);
            check_value("csr_rdata_o", rd, 32'(exp_dest[ch]));
            csr_access(1'b0, ch, POINTER, '0, rd);
            check_value("csr_rdata_o", rd, 32'(exp_ptr[ch]));
            csr_access(1'b0, ch, SIZE, '0, rd);
            check_value("csr_rdata_o", rd, 32'(exp_size[ch]));
        end

        // single packet
        launch(0, '0);
        wait_packet(0, 1);

        // credit stall on channel 1
        n = 0;
        while (owed[1] != 0 && n < 200) begin
            @(posedge clk);
            n++;
        end
        withhold[1] <= 1'b1;
        setup_channel(1, 8'h31, 16'h0F00, 8'd10);
        base = flits_seen[1];
        launch(1, '0);
        n = 0;
        while (flits_seen[1] - base < `NI_CREDITS && n < 200) begin
            @(posedge clk);
            n++;
        end
        repeat (30) @(posedge clk);
        assert (flits_seen[1] - base == `NI_CREDITS) else begin
            proto_errs++;
            $display("channel 1 sent %0d flits on %0d credits", flits_seen[1] - base,
                     `NI_CREDITS);
        end
        withhold[1] <= 1'b0;
        wait_packet(1, 1);

        // four channels at once
        setup_channel(1, 8'h11, 16'h0220, 8'd4);
        for (int ch = 0; ch < `NI_NUM_CH; ch++)
            launch(ch, '0);
        wait_packet(1, 2);
        launch(1, '0);      // queues again while channel 3 still waits
        wait_packet(0, 2);
        wait_packet(1, 3);
        wait_packet(2, 1);
        wait_packet(3, 1);

        // start while busy, then zero size
        launch(2, '0);
        csr_write(2, CTRL, 32'd1 << `NI_BIT_START);
        csr_access(1'b0, 2, STATUS, '0, rd);
        check_value("status.invalid", 32'(rd[`NI_BIT_INVALID]), 32'd1);
        wait_packet(2, 2);
        csr_write(2, CTRL, 32'd1 << `NI_BIT_INVALID);
        csr_access(1'b0, 2, STATUS, '0, rd);
        check_value("status.invalid", 32'(rd[`NI_BIT_INVALID]), 32'd0);
        setup_channel(3, 8'h13, 16'h0420, 8'd0);
        csr_write(3, CTRL, 32'd1 << `NI_BIT_START);
        csr_access(1'b0, 3, STATUS, '0, rd);
        check_value("status.zero", 32'(rd[`NI_BIT_ZERO]), 32'd1);
        check_value("status.busy", 32'(rd[`NI_BIT_START]), 32'd0);
        repeat (20) @(posedge clk);   // any header here is flagged
        csr_write(3, CTRL, 32'd1 << `NI_BIT_ZERO);
        csr_access(1'b0, 3, STATUS, '0, rd);
        check_value("status.zero", 32'(rd[`NI_BIT_ZERO]), 32'd0);

        // interrupt with and without the enable
        csr_write(1, CTRL, (32'd1 << `NI_BIT_DONE) | (32'd1 << `NI_BIT_IEN));
        check_value("irq_o", 32'(irq), 32'd0);
        launch(1, 32'd1 << `NI_BIT_IEN);
        n = 0;
        while (!irq && n < 500) begin
            @(posedge clk);
            n++;
        end
        check_value("irq_o", 32'(irq), 32'd1);
        check_value("pkts_done", 32'(pkts_done[1]), 32'd4);   // tail came first
        csr_write(1, CTRL, (32'd1 << `NI_BIT_DONE) | (32'd1 << `NI_BIT_IEN));
        check_value("irq_o", 32'(irq), 32'd0);
        csr_write(1, CTRL, 32'd1 << `NI_BIT_DONE);
        irq_must_low <= 1'b1;
        launch(1, '0);
        wait_packet(1, 5);
        repeat (4) @(posedge clk);
        csr_access(1'b0, 1, STATUS, '0, rd);
        check_value("status.done", 32'(rd[`NI_BIT_DONE]), 32'd1);
        irq_must_low <= 1'b0;

        repeat (10) @(posedge clk);
        $display("checks done: %0d value errors, %0d protocol errors",
                 value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns with the tests unfinished", WATCHDOG_NS);
        $display("checks done: %0d value errors, %0d protocol errors",
                 value_errs, proto_errs);
        $display("Test failed");
        $finish;
    end

endmodule

/* src.f */
+incdir+source
source/ni_pkg.sv
source/ni_csr.sv
source/ni_send_channel.sv
source/ni_send_arbiter.sv
source/ni_top.sv
verif/ni_tb.sv

/* Makefile */
# Verilator build, run, lint and clean for the send NI testbench

.PHONY: all run lint clean

all: run

obj_dir/Vni_tb: src.f $(wildcard source/*.sv) $(wildcard source/*.svh) verif/ni_tb.sv
	verilator --binary --timing --assert -f src.f --top-module ni_tb

run: obj_dir/Vni_tb
	./obj_dir/Vni_tb 2>&1 | tee sim.log
	@if grep -q "Test failed" sim.log || ! grep -q "Test passed" sim.log; then \
		echo "simulation FAILED"; exit 1; \
	fi
	@echo "simulation passed"

lint:
	verilator --lint-only -Wall --timing -f src.f --top-module ni_tb

clean:
	rm -rf obj_dir sim.log
